// File: compile.f
rtl/revo_pkg.sv
rtl/marker_input_front.sv
rtl/marker_qualifier.sv
rtl/marker_collector.sv
rtl/revo_marker_top.sv
tests/revo_marker_props.sv
tests/revo_marker_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the revo marker testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -j 0 --top-module revo_marker_tb -Mdir "$build_dir" -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vrevo_marker_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
	exit 0
fi
echo "pass message not found in $log_file"
exit 1

// File: tests/revo_marker_tb.sv
`timescale 1ns/1ns
`default_nettype none

module revo_marker_tb;

	logic clock;
	logic reset;
	revo_pkg::channel_mask_t revo_in;
	revo_pkg::channel_mask_t marker_out;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	revo_pkg::wb_addr_t wb_adr;
	revo_pkg::wb_data_t wb_write_data;
	revo_pkg::wb_data_t wb_read_data;
	logic wb_ack;

	int checks;
	int errors;
	logic [15:0] lfsr_state;
	revo_pkg::channel_mask_t marker_prev;
	revo_pkg::channel_mask_t exp_seen;
	int edge_count [revo_pkg::channels];
	int exp_edges [revo_pkg::channels];
	int exp_count [revo_pkg::channels];

	revo_marker_top revo_marker_top_inst (
		.clock(clock),
		.reset(reset),
		.revo_in(revo_in),
		.marker_out(marker_out),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_write_data(wb_write_data),
		.wb_read_data(wb_read_data),
		.wb_ack(wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// marker edges counted mid cycle away from the driving edge
	always @(negedge clock) begin
		for (int i = 0; i < revo_pkg::channels; i++) begin
			if (marker_out[i] && !marker_prev[i]) begin
				edge_count[i]++;
			end
		end
		marker_prev = marker_out;
	end

	// feedback polynomial x^16 + x^14 + x^13 + x^11 + 1
	// one step per bit taken
	function automatic int random_bits(input int n);
		int value;
		logic fb;
		value = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		assert (got == expected) else begin
			$display("MISMATCH %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// wishbone master
	// ------------------------------------------------------------------------
	task automatic await_ack(output revo_pkg::wb_data_t data);
		int waited;
		waited = 0;
		@(posedge clock);
		while (!wb_ack && waited < 8) begin
			@(posedge clock);
			waited++;
		end
		assert (wb_ack) else begin
			$display("no wb_ack within 8 clocks at address %0d", wb_adr);
			errors++;
		end
		// read data still belongs to the ack cycle here
		data = wb_read_data;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input revo_pkg::wb_addr_t addr, input int data);
		revo_pkg::wb_data_t ignored;
		@(posedge clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= addr;
		wb_write_data <= data;
		await_ack(ignored);
	endtask

	task automatic wb_read(input revo_pkg::wb_addr_t addr, input int expected,
			input string name);
		revo_pkg::wb_data_t data;
		@(posedge clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= addr;
		await_ack(data);
		check_value(name, int'(data), expected);
	endtask

	// ------------------------------------------------------------------------
	// marker stimulus
	// ------------------------------------------------------------------------
	task automatic pulse_channel(input revo_pkg::channel_mask_t bits, input int len);
		@(posedge clock);
		revo_in <= bits;
		repeat (len) @(posedge clock);
		revo_in <= '0;
	endtask

	task automatic wait_quiet();
		repeat (40) @(posedge clock);
	endtask

	// one qualified burst expected on this channel
	task automatic expect_marker(input int ch);
		int waited;
		waited = 0;
		while (edge_count[ch] <= exp_edges[ch] && waited < 40) begin
			@(posedge clock);
			waited++;
		end
		assert (edge_count[ch] > exp_edges[ch]) else begin
			$display("no marker_out edge on channel %0d within 40 clocks", ch);
			errors++;
		end
		exp_edges[ch]++;
		exp_count[ch]++;
		exp_seen[ch] = 1'b1;
	endtask

	task automatic check_all();
		check_value("marker_out", int'(marker_out), 0);
		wb_read(revo_pkg::addr_seen, int'(exp_seen), "seen");
		for (int i = 0; i < revo_pkg::channels; i++) begin
			wb_read(revo_pkg::wb_addr_t'(revo_pkg::addr_count_base + i), exp_count[i],
				$sformatf("count[%0d]", i));
			check_value($sformatf("marker_out[%0d] edges", i), edge_count[i], exp_edges[i]);
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic reset_defaults();
		wb_read(revo_pkg::addr_control, 32'hf, "enable_mask");
		check_all();
	endtask

	task automatic isolated_pulses();
		int ch;
		for (int n = 0; n < 3; n++) begin
			ch = random_bits(2);
			pulse_channel(revo_pkg::channel_mask_t'(1 << ch), random_bits(4) % 12 + 1);
			expect_marker(ch);
			wait_quiet();
			check_all();
		end
	endtask

	task automatic pulse_spacing();
		int ch;
		ch = random_bits(2);
		// short gap merges both pulses into one burst
		pulse_channel(revo_pkg::channel_mask_t'(1 << ch), random_bits(2) % 3 + 1);
		repeat (random_bits(2) % 3 + 1) @(posedge clock);
		pulse_channel(revo_pkg::channel_mask_t'(1 << ch), random_bits(2) % 3 + 1);
		expect_marker(ch);
		wait_quiet();
		check_all();
		for (int n = 0; n < 2; n++) begin
			pulse_channel(revo_pkg::channel_mask_t'(1 << ch), random_bits(2) + 1);
			expect_marker(ch);
			wait_quiet();
		end
		check_all();
	endtask

	task automatic masked_channel();
		int ch;
		int other;
		ch = random_bits(2);
		other = (ch + 1) % revo_pkg::channels;
		wb_write(revo_pkg::addr_control, 32'hf & ~(1 << ch));
		wb_read(revo_pkg::addr_control, 32'hf & ~(1 << ch), "enable_mask");
		pulse_channel(revo_pkg::channel_mask_t'((1 << ch) | (1 << other)),
			random_bits(3) + 1);
		expect_marker(other);
		wait_quiet();
		check_all();
		wb_write(revo_pkg::addr_control, 32'hf);
		wb_read(revo_pkg::addr_control, 32'hf, "enable_mask");
	endtask

	task automatic status_clearing();
		int ch;
		pulse_channel(4'hf, 2);
		for (int i = 0; i < revo_pkg::channels; i++) begin
			expect_marker(i);
		end
		wait_quiet();
		wb_write(revo_pkg::addr_seen, 32'h5);
		exp_seen = exp_seen & 4'ha;
		ch = random_bits(2);
		wb_write(revo_pkg::wb_addr_t'(revo_pkg::addr_count_base + ch), 32'h0);
		exp_count[ch] = 0;
		check_all();
		wb_read(3'd6, 0, "unmapped[6]");
		wb_read(3'd7, 0, "unmapped[7]");
	endtask

	initial begin
		reset = 1'b1;
		revo_in = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_write_data = '0;
		checks = 0;
		errors = 0;
		lfsr_state = 16'd62422;
		marker_prev = '0;
		exp_seen = '0;
		for (int i = 0; i < revo_pkg::channels; i++) begin
			edge_count[i] = 0;
			exp_edges[i] = 0;
			exp_count[i] = 0;
		end
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		reset_defaults();
		isolated_pulses();
		pulse_spacing();
		masked_channel();
		status_clearing();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/revo_marker_props.sv
`timescale 1ns/1ns
`default_nettype none

module revo_marker_props (
	input wire clock,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire revo_pkg::channel_mask_t marker_out,
	input wire revo_pkg::channel_mask_t enable_mask,
	input wire revo_pkg::frame_phase_t phase
);

	// ------------------------------------------------------------------------
	// wishbone handshake
	// ------------------------------------------------------------------------
	ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb)
		else $error("wb_ack high outside a bus cycle");

	ack_single: assert property (@(posedge clock) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	// marker_out lags the mask by one register stage
	masked_quiet: assert property (@(posedge clock) disable iff (reset)
		(marker_out & ~$past(enable_mask)) == '0)
		else $error("marker_out active on a masked channel");

	phase_order: assert property (@(posedge clock) disable iff (reset)
		!$past(reset) |-> phase == revo_pkg::frame_phase_t'($past(phase) + 2'd1))
		else $error("frame phase skipped its successor");

endmodule

// enable mask lives inside the collector, phase only at the top
bind revo_marker_top revo_marker_props revo_marker_props_inst (
	.clock(clock),
	.reset(reset),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.marker_out(marker_out),
	.enable_mask(marker_collector_inst.enable_mask),
	.phase(phase)
);

`default_nettype wire

// File: rtl/revo_marker_top.sv
`timescale 1ns/1ns
`default_nettype none

module revo_marker_top (
	input wire clock,
	input wire reset,
	input wire revo_pkg::channel_mask_t revo_in,
	output revo_pkg::channel_mask_t marker_out,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire revo_pkg::wb_addr_t wb_adr,
	input wire revo_pkg::wb_data_t wb_write_data,
	output revo_pkg::wb_data_t wb_read_data,
	output logic wb_ack
);

	revo_pkg::channel_mask_t synced;
	revo_pkg::frame_phase_t phase;
	revo_pkg::channel_mask_t decision;

	// synchronizers and the shared frame phase
	marker_input_front marker_input_front_inst (
		.clock(clock),
		.reset(reset),
		.revo_in(revo_in),
		.synced(synced),
		.phase(phase)
	);

	// ------------------------------------------------------------------------
	// one qualifier per channel
	// ------------------------------------------------------------------------
	for (genvar ch = 0; ch < revo_pkg::channels; ch++) begin : gen_qualifier
		marker_qualifier marker_qualifier_inst (
			.clock(clock),
			.reset(reset),
			.sample(synced[ch]),
			.phase(phase),
			.decision(decision[ch])
		);
	end

	// masking, counting and the register interface
	marker_collector marker_collector_inst (
		.clock(clock),
		.reset(reset),
		.decision(decision),
		.marker_out(marker_out),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_write_data(wb_write_data),
		.wb_read_data(wb_read_data),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

// File: rtl/marker_collector.sv
`timescale 1ns/1ns
`default_nettype none

module marker_collector (
	input wire clock,
	input wire reset,
	input wire revo_pkg::channel_mask_t decision,
	output revo_pkg::channel_mask_t marker_out,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire revo_pkg::wb_addr_t wb_adr,
	input wire revo_pkg::wb_data_t wb_write_data,
	output revo_pkg::wb_data_t wb_read_data,
	output logic wb_ack
);

	revo_pkg::channel_mask_t enable_mask;
	revo_pkg::channel_mask_t seen;
	revo_pkg::channel_mask_t masked;
	revo_pkg::channel_mask_t rise;
	revo_pkg::channel_mask_t write_bits;
	revo_pkg::count_t counters [revo_pkg::channels];
	logic write_strobe;

	// ------------------------------------------------------------------------
	// marker path
	// ------------------------------------------------------------------------
	assign masked = decision & enable_mask;
	// marker_out is last cycle's masked decision
	assign rise = masked & ~marker_out;

	always_ff @(posedge clock) begin
		if (reset) begin
			marker_out <= '0;
		end else begin
			marker_out <= masked;
		end
	end

	// ------------------------------------------------------------------------
	// wishbone slave
	// ------------------------------------------------------------------------
	// one cycle of latency, ack drops after a single cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;
		end
	end

	// writes land on the ack cycle
	assign write_strobe = wb_ack & wb_cyc & wb_stb & wb_we;
	assign write_bits = wb_write_data[revo_pkg::channels-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_mask <= '1;
		end else if (write_strobe && wb_adr == revo_pkg::addr_control) begin
			enable_mask <= write_bits;
		end
	end

	// a new edge wins over a clear in the same cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			seen <= '0;
		end else if (write_strobe && wb_adr == revo_pkg::addr_seen) begin
			seen <= (seen & ~write_bits) | rise;
		end else begin
			seen <= seen | rise;
		end
	end

	// per channel counters, any write clears
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < revo_pkg::channels; i++) begin
				counters[i] <= '0;
			end
		end else begin
			for (int i = 0; i < revo_pkg::channels; i++) begin
				if (write_strobe &&
					wb_adr == revo_pkg::wb_addr_t'(revo_pkg::addr_count_base + i)) begin
					counters[i] <= revo_pkg::count_t'(rise[i]);
				end else begin
					counters[i] <= counters[i] + revo_pkg::count_t'(rise[i]);
				end
			end
		end
	end

	// read mux, unmapped addresses give zero
	always_comb begin
		wb_read_data = '0;
		if (wb_adr == revo_pkg::addr_control) begin
			wb_read_data = revo_pkg::wb_data_t'(enable_mask);
		end else if (wb_adr == revo_pkg::addr_seen) begin
			wb_read_data = revo_pkg::wb_data_t'(seen);
		end else begin
			for (int i = 0; i < revo_pkg::channels; i++) begin
				if (wb_adr == revo_pkg::wb_addr_t'(revo_pkg::addr_count_base + i)) begin
					wb_read_data = revo_pkg::wb_data_t'(counters[i]);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/marker_qualifier.sv
`timescale 1ns/1ns
`default_nettype none

module marker_qualifier (
	input wire clock,
	input wire reset,
	input wire sample,
	input wire revo_pkg::frame_phase_t phase,
	output logic decision
);

	revo_pkg::stream_t history;
	logic [revo_pkg::older_width-1:0] older;
	logic [revo_pkg::max_duration-1:0] recent;
	logic older_any;
	logic recent_any;
	logic pending;

	// sample history, newest in bit 0
	always_ff @(posedge clock) begin
		if (reset) begin
			history <= '0;
		end else begin
			history <= {history[revo_pkg::stream_width-2:0], sample};
		end
	end

	// snapshot of both windows once per frame
	always_ff @(posedge clock) begin
		if (phase == revo_pkg::phase_sample) begin
			older <= history[revo_pkg::stream_width-1:revo_pkg::max_duration];
			recent <= history[revo_pkg::max_duration-1:0];
		end
	end

	// ------------------------------------------------------------------------
	// frame sequence
	// ------------------------------------------------------------------------
	// arm on recent activity, veto on older activity, so only a burst
	// after a quiet history survives to the next frame
	always_ff @(posedge clock) begin
		if (reset) begin
			older_any <= 1'b0;
			recent_any <= 1'b0;
			pending <= 1'b0;
			decision <= 1'b0;
		end else begin
			case (phase)
				revo_pkg::phase_sample: begin
					// held for the whole frame
					decision <= pending;
				end
				revo_pkg::phase_reduce: begin
					older_any <= |older;
					recent_any <= |recent;
					pending <= 1'b0;
				end
				revo_pkg::phase_arm: begin
					if (recent_any) begin
						pending <= 1'b1;
					end
				end
				default: begin
					if (older_any) begin
						pending <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/marker_input_front.sv
`timescale 1ns/1ns
`default_nettype none

module marker_input_front (
	input wire clock,
	input wire reset,
	input wire revo_pkg::channel_mask_t revo_in,
	output revo_pkg::channel_mask_t synced,
	output revo_pkg::frame_phase_t phase
);

	// ------------------------------------------------------------------------
	// input synchronizers
	// ------------------------------------------------------------------------
	revo_pkg::channel_mask_t sync_chain [revo_pkg::sync_stages];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < revo_pkg::sync_stages; i++) begin
				sync_chain[i] <= '0;
			end
		end else begin
			// stage 0 is the only flop that sees the raw input
			sync_chain[0] <= revo_in;
			for (int i = 1; i < revo_pkg::sync_stages; i++) begin
				sync_chain[i] <= sync_chain[i-1];
			end
		end
	end

	assign synced = sync_chain[revo_pkg::sync_stages-1];

	// ------------------------------------------------------------------------
	// frame sequencer
	// ------------------------------------------------------------------------
	// free running, shared by every channel so all frames line up
	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= revo_pkg::phase_sample;
		end else begin
			case (phase)
				revo_pkg::phase_sample: begin
					phase <= revo_pkg::phase_reduce;
				end
				revo_pkg::phase_reduce: begin
					phase <= revo_pkg::phase_arm;
				end
				revo_pkg::phase_arm: begin
					phase <= revo_pkg::phase_veto;
				end
				default: begin
					phase <= revo_pkg::phase_sample;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/revo_pkg.sv
`default_nettype none

package revo_pkg;

	// ------------------------------------------------------------------------
	// channel and history geometry
	// ------------------------------------------------------------------------
	localparam int channels = 4;
	localparam int stream_width = 16;
	// recent window, newest samples
	localparam int max_duration = 8;
	// older window takes what is left of the history
	localparam int older_width = stream_width - max_duration;
	localparam int sync_stages = 3;
	localparam int count_width = 16;

	// wishbone geometry
	localparam int wb_addr_width = 3;
	localparam int wb_data_width = 32;

	typedef logic [stream_width-1:0] stream_t;
	typedef logic [channels-1:0] channel_mask_t;
	typedef logic [count_width-1:0] count_t;
	typedef logic [wb_addr_width-1:0] wb_addr_t;
	typedef logic [wb_data_width-1:0] wb_data_t;

	// register map, word addresses
	localparam wb_addr_t addr_control = 3'd0;
	localparam wb_addr_t addr_seen = 3'd1;
	// one counter per channel from here up
	localparam wb_addr_t addr_count_base = 3'd2;

	// frame phases, taken in this order
	typedef enum logic [1:0] {
		phase_sample,
		phase_reduce,
		phase_arm,
		phase_veto
	} frame_phase_t;

endpackage

`default_nettype wire
